// File: Bender.yml
package:
  name: zx_ula

sources:
  - files:
      - source/ula_pkg.sv
      - source/vram_if.sv
      - source/raster_timing.sv
      - source/screen_fetch.sv
      - source/io_ports.sv
      - source/mem_mapper.sv
      - source/vram_arbiter.sv
      - source/zx_ula_top.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/ula_assertions.sv
      - sim/tb_zx_ula.sv

// File: flist.f
source/ula_pkg.sv
source/vram_if.sv
source/raster_timing.sv
source/screen_fetch.sv
source/io_ports.sv
source/mem_mapper.sv
source/vram_arbiter.sv
source/zx_ula_top.sv
sim/tb_clock.sv
sim/ula_assertions.sv
sim/tb_zx_ula.sv

// File: sim/tb_clock.sv
module tb_clock (
	output logic clk14,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk14 = 1'b0;
		forever #5 clk14 = ~clk14;
	end

	// held low over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk14);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: sim/tb_zx_ula.sv
module tb_zx_ula;

	timeunit 1ns;
	timeprecision 100ps;

	// bank 5 is page 11_101 of the video RAM
	localparam int SCREEN_BASE = 'h74000;
	localparam int VRAM_WORDS = 1 << 19;

	logic clk14;
	logic rst_n;
	logic timing_128;
	ula_pkg::cpu_addr_t cpu_a;
	ula_pkg::byte_t cpu_d_in;
	logic n_mreq;
	logic n_iorq;
	logic n_rd;
	logic n_wr;
	logic n_m1;
	logic n_rfsh;
	logic [4:0] kd;
	logic tape_in;
	ula_pkg::byte_t vram_d;
	logic clkcpu;
	logic n_int;
	ula_pkg::byte_t cpu_d_out;
	logic cpu_d_oe;
	ula_pkg::vram_addr_t va_out;
	logic n_vrd;
	logic n_vwr;
	logic n_romcs;
	logic [2:0] ra;
	logic r;
	logic g;
	logic b;
	logic i;
	logic hsync;
	logic vsync;
	logic csync;
	logic beeper;
	logic tape_out;
	ula_pkg::rgbi_t rgbi;
	ula_pkg::byte_t vram [0:VRAM_WORDS - 1];
	int value_errors = 0;
	int timeouts = 0;

	tb_clock u_clock (
		.clk14(clk14),
		.rst_n(rst_n)
	);

	zx_ula_top DUT (
		.*
	);

	// video RAM answers the address pins without delay
	assign vram_d = vram[va_out];
	assign rgbi = {i, g, r, b};

	task automatic check_byte(input string name, input ula_pkg::byte_t got,
		input ula_pkg::byte_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_page(input string name, input ula_pkg::ram_page_t got,
		input ula_pkg::ram_page_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_rgbi(input string name, input ula_pkg::rgbi_t got,
		input ula_pkg::rgbi_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic logic sync_level(input string name);
		case (name)
			"hsync": return hsync;
			"vsync": return vsync;
			default: return n_int;
		endcase
	endfunction

	// counts falling clock edges until the named output changes to level
	task automatic wait_edge(input string name, input logic level, input int limit,
		output int cycles);
		logic prev;
		logic found;
		prev = sync_level(name);
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < limit) begin
			@(negedge clk14);
			cycles++;
			found = prev != level && sync_level(name) == level;
			prev = sync_level(name);
		end
		if (!found) begin
			timeouts++;
			$display("Timeout at %0t: %s did not go to %b within %0d clocks",
				$time, name, level, limit);
		end
	endtask

	task automatic io_write(input ula_pkg::cpu_addr_t addr, input ula_pkg::byte_t data);
		@(posedge clk14);
		#1;
		cpu_a = addr;
		cpu_d_in = data;
		n_iorq = 1'b0;
		n_wr = 1'b0;
		@(posedge clk14);
		#1;
		n_iorq = 1'b1;
		n_wr = 1'b1;
	endtask

	task automatic io_read(input ula_pkg::cpu_addr_t addr, output ula_pkg::byte_t data);
		int n;
		@(posedge clk14);
		#1;
		cpu_a = addr;
		n_iorq = 1'b0;
		n_rd = 1'b0;
		n = 0;
		while (!cpu_d_oe && n < 8) begin
			@(negedge clk14);
			n++;
		end
		if (!cpu_d_oe) begin
			timeouts++;
			$display("Timeout at %0t: no data driven for port read %h", $time, addr);
		end
		data = cpu_d_out;
		@(posedge clk14);
		#1;
		n_iorq = 1'b1;
		n_rd = 1'b1;
	endtask

	task automatic mem_read(input ula_pkg::cpu_addr_t addr, output ula_pkg::ram_page_t page,
		output logic vrd_n, output logic romcs_n, output logic [2:0] rom_page);
		@(posedge clk14);
		#1;
		cpu_a = addr;
		n_mreq = 1'b0;
		n_rd = 1'b0;
		// mapper outputs move on the falling edge, a pending screen slot ends first
		@(negedge clk14);
		@(negedge clk14);
		#1;
		page = va_out[18:13];
		vrd_n = n_vrd;
		romcs_n = n_romcs;
		rom_page = ra;
		@(posedge clk14);
		#1;
		n_mreq = 1'b1;
		n_rd = 1'b1;
	endtask

	task automatic mem_write(input ula_pkg::cpu_addr_t addr, output ula_pkg::ram_page_t page,
		output logic vwr_n, output logic vrd_n);
		@(posedge clk14);
		#1;
		cpu_a = addr;
		n_mreq = 1'b0;
		n_wr = 1'b0;
		@(negedge clk14);
		@(negedge clk14);
		#1;
		page = va_out[18:13];
		vwr_n = n_vwr;
		vrd_n = n_vrd;
		@(posedge clk14);
		#1;
		n_mreq = 1'b1;
		n_wr = 1'b1;
	endtask

	// CPU clock runs at a quarter of clk14
	task automatic check_cpu_clock();
		int n;
		int toggles;
		logic prev;
		@(negedge clk14);
		prev = clkcpu;
		toggles = 0;
		for (n = 0; n < 16; n++) begin
			@(negedge clk14);
			if (clkcpu !== prev)
				toggles++;
			prev = clkcpu;
		end
		check_int("clkcpu toggles in 16 clocks", toggles, 8);
	endtask

	task automatic check_line_timing(input logic mode, input int line_cycles);
		int cycles;
		@(posedge clk14);
		#1;
		timing_128 = mode;
		// lines right after a mode change can be short
		wait_edge("hsync", 1'b1, 2 * line_cycles, cycles);
		wait_edge("hsync", 1'b1, 2 * line_cycles, cycles);
		wait_edge("hsync", 1'b1, 2 * line_cycles, cycles);
		check_int("hsync period", cycles, line_cycles);
		// composite sync follows hsync outside the vertical pulse
		if (!vsync)
			check_bit("csync", csync, 1'b1);
		wait_edge("hsync", 1'b0, line_cycles, cycles);
		check_int("hsync high clocks", cycles, 66);
		if (!vsync)
			check_bit("csync", csync, 1'b0);
		check_cpu_clock();
	endtask

	task automatic check_frame_timing(input int frame_cycles, input int int_cycles);
		int cycles;
		int low_cycles;
		int int_falls;
		logic prev_vs;
		logic prev_int;
		logic found;
		wait_edge("vsync", 1'b1, 2 * frame_cycles, cycles);
		cycles = 0;
		low_cycles = 0;
		int_falls = 0;
		prev_vs = vsync;
		prev_int = n_int;
		found = 1'b0;
		while (!found && cycles < 2 * frame_cycles) begin
			@(negedge clk14);
			cycles++;
			if (!n_int)
				low_cycles++;
			if (prev_int && !n_int)
				int_falls++;
			found = !prev_vs && vsync;
			prev_vs = vsync;
			prev_int = n_int;
		end
		if (!found) begin
			timeouts++;
			$display("Timeout at %0t: no second vsync within %0d clocks", $time, cycles);
		end
		check_int("vsync period", cycles, frame_cycles);
		check_int("n_int pulses per frame", int_falls, 1);
		check_int("n_int low clocks", low_cycles, int_cycles);
	endtask

	task automatic check_port_fe();
		logic [31:0] rnd;
		ula_pkg::byte_t data;
		ula_pkg::byte_t rd;
		int cycles;
		int n;
		rnd = $urandom;
		data = rnd[7:0];
		// a black border would look the same as blanking
		if (data[2:0] == 3'd0)
			data[2:0] = 3'd6;
		io_write(16'h00fe, data);
		@(negedge clk14);
		check_bit("beeper", beeper, data[4]);
		check_bit("tape_out", tape_out, data[3]);
		@(posedge clk14);
		#1;
		tape_in = 1'b1;
		@(negedge clk14);
		check_bit("tape_out", tape_out, !data[3]);
		// left border, 48 columns after hsync ends on a line outside vsync
		wait_edge("hsync", 1'b0, 2 * 912, cycles);
		for (n = 0; n < 20 && vsync; n++)
			wait_edge("hsync", 1'b0, 2 * 912, cycles);
		repeat (96) @(negedge clk14);
		check_rgbi("rgbi", rgbi, {1'b0, data[2:0]});
		@(posedge clk14);
		#1;
		kd = rnd[20:16];
		tape_in = rnd[24];
		io_read(16'h00fe, rd);
		check_byte("port #FE", rd, {1'b1, rnd[24], 1'b1, rnd[20:16]});
	endtask

	task automatic check_port_7ffd();
		logic [31:0] rnd;
		ula_pkg::byte_t data;
		ula_pkg::rambank_t bank;
		ula_pkg::ram_page_t page;
		logic vrd_n;
		logic vwr_n;
		logic romcs_n;
		logic [2:0] rom_page;
		rnd = $urandom;
		// normal screen, lock open
		data = {2'b00, rnd[4], 1'b0, rnd[2:0]};
		bank = rnd[2:0];
		io_write(16'h7ffd, data);
		mem_read({2'b11, rnd[13], rnd[12:0]}, page, vrd_n, romcs_n, rom_page);
		check_page("va_out[18:13]", page, {2'b11, bank, rnd[13]});
		check_bit("n_vrd", vrd_n, 1'b0);
		check_bit("n_romcs", romcs_n, 1'b1);
		mem_write({2'b11, ~rnd[13], rnd[12:0]}, page, vwr_n, vrd_n);
		check_page("va_out[18:13]", page, {2'b11, bank, ~rnd[13]});
		check_bit("n_vwr", vwr_n, 1'b0);
		check_bit("n_vrd", vrd_n, 1'b1);
		mem_read({2'b00, rnd[27:14]}, page, vrd_n, romcs_n, rom_page);
		check_bit("n_romcs", romcs_n, 1'b0);
		check_bit("n_vrd", vrd_n, 1'b1);
		check_int("ra", rom_page, rnd[4]);
		// lock, then try another bank
		io_write(16'h7ffd, data | 8'h20);
		io_write(16'h7ffd, {2'b00, rnd[4], 1'b0, ~bank});
		mem_read(16'hc000, page, vrd_n, romcs_n, rom_page);
		check_page("va_out[18:13]", page, {2'b11, bank, 1'b0});
	endtask

	task automatic check_screen(input ula_pkg::byte_t bitmap_val,
		input ula_pkg::rgbi_t expected);
		int a;
		int line;
		int cycles;
		ula_pkg::byte_t rd;
		for (a = 0; a < 'h1800; a++)
			vram[SCREEN_BASE + a] = bitmap_val;
		// ink 2, paper 0, no bright, no flash
		for (a = 'h1800; a < 'h1b00; a++)
			vram[SCREEN_BASE + a] = 8'h02;
		// vsync ends on line 256, the 156th hsync after that is on line 100
		wait_edge("vsync", 1'b0, 2 * 311 * 912, cycles);
		for (line = 0; line < 156; line++)
			wait_edge("hsync", 1'b1, 2 * 912, cycles);
		// from column 340 to about column 128 of the next line
		repeat (488) @(negedge clk14);
		repeat (32) begin
			@(negedge clk14);
			check_rgbi("rgbi", rgbi, expected);
		end
		io_read(16'h00ff, rd);
		check_byte("port #FF", rd, 8'h02);
	endtask

	initial begin
		int n;
		int a;
		int assert_fails;
		void'($urandom(32'he1bf2be2));
		timing_128 = 1'b1;
		cpu_a = '0;
		cpu_d_in = '0;
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_m1 = 1'b1;
		n_rfsh = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		for (a = 0; a < VRAM_WORDS; a++)
			vram[a] = ula_pkg::byte_t'(a ^ (a >> 8) ^ (a >> 16));
		n = 0;
		while (rst_n !== 1'b1 && n < 10) begin
			@(posedge clk14);
			n++;
		end
		if (rst_n !== 1'b1) begin
			timeouts++;
			$display("Timeout at %0t: reset was not released", $time);
		end
		// Pentagon first, then 128K for the rest of the run
		check_line_timing(1'b0, 896);
		check_frame_timing(320 * 896, 132);
		check_line_timing(1'b1, 912);
		check_frame_timing(311 * 912, 118);
		check_port_fe();
		check_port_7ffd();
		// red ink on every pixel, then all paper
		check_screen(8'hff, 4'b0010);
		check_screen(8'h00, 4'b0000);
		assert_fails = DUT.u_arbiter.u_arb_chk.fail_count +
			DUT.u_raster.u_raster_chk.fail_count;
		$display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
			value_errors, timeouts, assert_fails);
		if (value_errors == 0 && timeouts == 0 && assert_fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim/ula_assertions.sv
module ula_assertions (
	input logic clk14,
	input logic rst_n,
	input logic screen_grant,
	input logic cpu_rd,
	input logic cpu_wr,
	input logic hsync
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// screen slots only open while the mapper has no CPU access to video RAM
	fetch_in_cpu_idle: assert property (
		@(negedge clk14) disable iff (!rst_n)
		screen_grant |-> !cpu_rd && !cpu_wr
	) else begin
		fail_count++;
		$error("screen fetch granted during a CPU video RAM access");
	end

	// hsync pulse is 33 columns of two clocks
	hsync_width: assert property (
		@(posedge clk14) disable iff (!rst_n)
		$rose(hsync) |-> ##[1:66] !hsync
	) else begin
		fail_count++;
		$error("hsync stayed high for more than 66 clocks");
	end

endmodule

bind vram_arbiter ula_assertions u_arb_chk (
	.clk14(clk14),
	.rst_n(rst_n),
	.screen_grant(vif.screen_grant),
	.cpu_rd(vif.cpu_rd),
	.cpu_wr(vif.cpu_wr),
	.hsync(1'b0)
);

bind raster_timing ula_assertions u_raster_chk (
	.clk14(clk14),
	.rst_n(rst_n),
	.screen_grant(1'b0),
	.cpu_rd(1'b0),
	.cpu_wr(1'b0),
	.hsync(hsync)
);

// File: source/io_ports.sv
module io_ports (
	input logic clk14,
	input logic rst_n,
	input ula_pkg::cpu_addr_t cpu_a,
	input logic n_iorq,
	input logic n_rd,
	input logic n_wr,
	input logic n_m1,
	input ula_pkg::byte_t cpu_d_in,
	input logic [4:0] kd,
	input logic tape_in,
	input ula_pkg::byte_t attr_latch,
	output ula_pkg::byte_t cpu_d_out,
	output logic cpu_d_oe,
	output ula_pkg::rambank_t border,
	output logic beeper,
	output logic tape_out,
	output ula_pkg::rambank_t rambank,
	output logic video_bank,
	output logic rom_bank
);

	logic io_cyc;
	logic fe_cs;
	logic p7ffd_cs;
	logic ff_cs;
	logic fe_rd;
	logic ff_rd;
	logic [ula_pkg::FE_BEEPER:0] port_fe;
	logic [ula_pkg::P7FFD_LOCK:0] port_7ffd;

	// m1 with iorq is an interrupt acknowledge, not a port cycle
	assign io_cyc = !n_iorq && n_m1;
	assign fe_cs = io_cyc && !cpu_a[ula_pkg::FE_DECODE_BIT];
	assign p7ffd_cs = io_cyc && !cpu_a[ula_pkg::P7FFD_DECODE_BIT] &&
		!cpu_a[ula_pkg::P7FFD_HIGH_BIT];
	// unclaimed reads and interrupt acknowledge see the floating bus
	assign ff_cs = !n_iorq && ((cpu_a[ula_pkg::FF_DECODE_BIT] && !n_rd) || !n_m1);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			port_fe <= '0;
			port_7ffd <= '0;
			fe_rd <= 1'b0;
			ff_rd <= 1'b0;
		end else begin
			if (fe_cs && !n_wr)
				port_fe <= cpu_d_in[ula_pkg::FE_BEEPER:0];
			// once locked, #7FFD stays until reset
			if (p7ffd_cs && !n_wr && !port_7ffd[ula_pkg::P7FFD_LOCK])
				port_7ffd <= cpu_d_in[ula_pkg::P7FFD_LOCK:0];
			fe_rd <= fe_cs && !n_rd;
			ff_rd <= ff_cs && !(fe_cs && !n_rd);
		end
	end

	assign cpu_d_oe = fe_rd | ff_rd;
	assign cpu_d_out = fe_rd ? {1'b1, tape_in, 1'b1, kd} : attr_latch;

	assign border = port_fe[2:0];
	assign beeper = port_fe[ula_pkg::FE_BEEPER];
	// MIC output mixed with the EAR input
	assign tape_out = port_fe[ula_pkg::FE_TAPE_OUT] ^ tape_in;

	assign rambank = port_7ffd[ula_pkg::P7FFD_BANK_MSB:0];
	assign video_bank = port_7ffd[ula_pkg::P7FFD_VBANK];
	assign rom_bank = port_7ffd[ula_pkg::P7FFD_ROM];

endmodule

// File: source/mem_mapper.sv
module mem_mapper (
	input logic clk14,
	input ula_pkg::cpu_addr_t cpu_a,
	input logic n_mreq,
	input logic n_rfsh,
	input logic n_rd,
	input logic n_wr,
	input ula_pkg::rambank_t rambank,
	input logic rom_bank,
	vram_if.mapper vif,
	output logic n_romcs,
	output logic [2:0] ra
);

	logic rom_cycle;
	logic ram_cycle;
	ula_pkg::rambank_t bank;
	logic romcs_q;
	logic sel_q;
	logic rd_q;
	logic wr_q;
	ula_pkg::ram_page_t page_q;

	// refresh cycles never reach ROM or RAM
	assign rom_cycle = !n_mreq && n_rfsh && cpu_a[15:14] == 2'b00;
	assign ram_cycle = !n_mreq && n_rfsh && cpu_a[15:14] != 2'b00;

	always_comb begin
		case (cpu_a[15:14])
			2'b01: bank = ula_pkg::BANK_4000;
			2'b10: bank = ula_pkg::BANK_8000;
			// C000, the ROM quarter never uses it
			default: bank = rambank;
		endcase
	end

	// sampled half a clock after the CPU strobes settle
	always_ff @(negedge clk14) begin
		romcs_q <= !rom_cycle;
		sel_q <= ram_cycle;
		rd_q <= ram_cycle && !n_rd;
		wr_q <= ram_cycle && !n_wr;
		page_q <= {ula_pkg::RAM_PAGE_HI, bank, cpu_a[13]};
	end

	// strobes drop as soon as the CPU ends the cycle
	assign n_romcs = romcs_q | n_mreq;
	assign ra = {2'b00, rom_bank};

	assign vif.cpu_sel = sel_q;
	assign vif.cpu_page = page_q;
	assign vif.cpu_rd = rd_q & !n_rd;
	assign vif.cpu_wr = wr_q & !n_wr;

endmodule

// File: source/raster_timing.sv
module raster_timing (
	input logic clk14,
	input logic rst_n,
	input logic timing_128,
	output ula_pkg::hcount_t hc,
	output logic hc0_odd,
	output ula_pkg::vcount_t vc,
	output logic line_end,
	output logic blank,
	output logic screen_load,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic n_int,
	output logic blink,
	output logic clkcpu
);

	ula_pkg::hcount2_t hc0;
	logic last_line;
	logic hsync0;
	logic vsync0;
	logic int_window;
	logic int0;
	logic [4:0] blink_cnt;

	// one column is two pixel clocks
	assign hc = hc0[9:1];
	assign hc0_odd = hc0[0];

	always_comb begin
		if (timing_128) begin
			line_end = hc0 >= 2 * ula_pkg::H_TOTAL_128 - 1;
			last_line = vc >= ula_pkg::V_TOTAL_128 - 1;
			hsync0 = hc >= ula_pkg::H_SYNC_START_128 && hc < ula_pkg::H_SYNC_STOP_128;
			vsync0 = vc >= ula_pkg::V_SYNC_START_128 && vc < ula_pkg::V_SYNC_STOP_128;
			blank = vsync0 ||
				(hc >= ula_pkg::H_BLANK_START_128 && hc < ula_pkg::H_BLANK_STOP_128);
			int_window = vc == ula_pkg::INT_LINE_128 &&
				hc >= ula_pkg::INT_FROM_128 && hc < ula_pkg::INT_TO_128;
		end else begin
			line_end = hc0 >= 2 * ula_pkg::H_TOTAL_PENT - 1;
			last_line = vc >= ula_pkg::V_TOTAL_PENT - 1;
			hsync0 = hc >= ula_pkg::H_SYNC_START_PENT && hc < ula_pkg::H_SYNC_STOP_PENT;
			vsync0 = vc >= ula_pkg::V_SYNC_START_PENT && vc < ula_pkg::V_SYNC_STOP_PENT;
			blank = vsync0 ||
				(hc >= ula_pkg::H_BLANK_START_PENT && hc < ula_pkg::H_BLANK_STOP_PENT);
			int_window = vc == ula_pkg::INT_LINE_PENT &&
				hc >= ula_pkg::INT_FROM_PENT && hc < ula_pkg::INT_TO_PENT;
		end
	end

	// the last half-pixel of the line also fetches the first byte of the next one
	assign screen_load = vc < ula_pkg::V_AREA && (hc < ula_pkg::H_AREA || line_end);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc0 <= '0;
			if (last_line)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end else begin
			hc0 <= hc0 + 1'b1;
		end
	end

	// syncs move on column boundaries only
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b0;
		end else if (hc0_odd) begin
			hsync <= hsync0;
			vsync <= vsync0;
			csync <= hsync0 ^ vsync0;
		end
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			int0 <= 1'b0;
			n_int <= 1'b1;
			blink_cnt <= '0;
			clkcpu <= 1'b0;
		end else begin
			int0 <= int_window;
			n_int <= ~int0;
			if (line_end && last_line)
				blink_cnt <= blink_cnt + 1'b1;
			// half the column rate, 3.5 MHz
			clkcpu <= hc[0];
		end
	end

	// flash phase flips every 16 frames
	assign blink = blink_cnt[4];

endmodule

// File: source/screen_fetch.sv
module screen_fetch (
	input logic clk14,
	input logic rst_n,
	input ula_pkg::hcount_t hc,
	input logic hc0_odd,
	input ula_pkg::vcount_t vc,
	input logic line_end,
	input logic blank,
	input logic screen_load,
	input logic blink,
	input ula_pkg::rambank_t border,
	input logic video_bank,
	vram_if.fetch vif,
	output ula_pkg::rgbi_t rgbi,
	output ula_pkg::byte_t attr_latch
);

	ula_pkg::fetch_phase_e phase;
	logic [13:0] bitmap_ofs;
	logic [13:0] attr_ofs;
	ula_pkg::byte_t attr_next;
	ula_pkg::byte_t bitmap_next;
	ula_pkg::byte_t attr;
	ula_pkg::byte_t bitmap;
	logic screen_show;
	logic screen_update;
	logic pixel;
	logic [2:0] colour;

	// attr on even half-pixels, bitmap on odd ones, only while the CPU is off video RAM
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			phase <= ula_pkg::IDLE;
		else if (screen_load && !vif.cpu_sel)
			phase <= hc0_odd ? ula_pkg::ATTR : ula_pkg::BITMAP;
		else
			phase <= ula_pkg::IDLE;
	end

	// spectrum screen layout inside a 16K bank
	assign bitmap_ofs = {1'b0, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	assign attr_ofs = {4'b0110, vc[7:3], hc[7:3]};

	assign vif.screen_req = phase != ula_pkg::IDLE;
	// bank 5, or bank 7 for the shadow screen
	assign vif.screen_addr = {ula_pkg::RAM_PAGE_HI, 1'b1, video_bank, 1'b1,
		phase == ula_pkg::ATTR ? attr_ofs : bitmap_ofs};

	always_ff @(posedge clk14) begin
		if (vif.screen_grant && phase == ula_pkg::ATTR)
			attr_next <= vif.vram_d;
		else if (!screen_load)
			attr_next <= 8'hff;
		if (vif.screen_grant && phase == ula_pkg::BITMAP)
			bitmap_next <= vif.vram_d;
	end

	// floating bus value for port #FF
	assign attr_latch = attr_next;

	assign screen_show = vc < ula_pkg::V_AREA && hc >= ula_pkg::SCREEN_DELAY - 1 &&
		hc < ula_pkg::H_AREA + ula_pkg::SCREEN_DELAY - 1;
	// last even half-pixel of each 8-column group
	assign screen_update = screen_load && hc[2:0] == 3'b111 && !hc0_odd;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			attr <= '0;
			bitmap <= '0;
		end else begin
			// border is drawn as paper with an empty bitmap
			if (!screen_show)
				attr <= {2'b00, border, 3'b000};
			else if (screen_update)
				attr <= attr_next;
			if (screen_update)
				bitmap <= bitmap_next;
			else if (line_end)
				bitmap <= '0;
			else if (hc0_odd)
				bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	assign pixel = bitmap[7] ^ (attr[7] & blink);
	assign colour = pixel ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			rgbi <= '0;
		else if (hc0_odd) begin
			if (blank)
				rgbi <= '0;
			else
				rgbi <= {(|colour) & attr[6], colour};
		end
	end

endmodule

// File: source/ula_pkg.sv
package ula_pkg;

	typedef logic [8:0] hcount_t;
	typedef logic [9:0] hcount2_t;
	typedef logic [8:0] vcount_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [18:0] vram_addr_t;
	typedef logic [5:0] ram_page_t;
	// i, g, r, b from msb down
	typedef logic [3:0] rgbi_t;
	typedef logic [2:0] rambank_t;

	// screen fetch sub-cycle
	typedef enum logic [1:0] {IDLE, ATTR, BITMAP} fetch_phase_e;

	localparam int H_AREA = 256;
	localparam int V_AREA = 192;
	localparam int SCREEN_DELAY = 8;

	// 128K raster
	localparam int H_LBORDER_128 = 48 - SCREEN_DELAY;
	localparam int H_RBORDER_128 = 48 + SCREEN_DELAY;
	localparam int H_BLANK1_128 = 28;
	localparam int H_SYNC_128 = 33;
	localparam int H_BLANK2_128 = 43;
	localparam int H_TOTAL_128 = H_AREA + H_RBORDER_128 + H_BLANK1_128 + H_SYNC_128
		+ H_BLANK2_128 + H_LBORDER_128;
	localparam int V_BBORDER_128 = 56;
	localparam int V_SYNC_128 = 8;
	localparam int V_TBORDER_128 = 55;
	localparam int V_TOTAL_128 = V_AREA + V_BBORDER_128 + V_SYNC_128 + V_TBORDER_128;

	// Pentagon raster
	localparam int H_LBORDER_PENT = 72 - SCREEN_DELAY;
	localparam int H_RBORDER_PENT = 56 + SCREEN_DELAY;
	localparam int H_BLANK1_PENT = 8;
	localparam int H_SYNC_PENT = 33;
	localparam int H_BLANK2_PENT = 23;
	localparam int H_TOTAL_PENT = H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT
		+ H_BLANK2_PENT + H_LBORDER_PENT;
	localparam int V_BBORDER_PENT = 56;
	localparam int V_SYNC_PENT = 8;
	localparam int V_TBORDER_PENT = 64;
	localparam int V_TOTAL_PENT = V_AREA + V_BBORDER_PENT + V_SYNC_PENT + V_TBORDER_PENT;

	// sync and blank windows in columns and lines
	localparam int H_BLANK_START_128 = H_AREA + H_RBORDER_128;
	localparam int H_SYNC_START_128 = H_BLANK_START_128 + H_BLANK1_128;
	localparam int H_SYNC_STOP_128 = H_SYNC_START_128 + H_SYNC_128;
	localparam int H_BLANK_STOP_128 = H_SYNC_STOP_128 + H_BLANK2_128;
	localparam int V_SYNC_START_128 = V_AREA + V_BBORDER_128;
	localparam int V_SYNC_STOP_128 = V_SYNC_START_128 + V_SYNC_128;
	localparam int H_BLANK_START_PENT = H_AREA + H_RBORDER_PENT;
	localparam int H_SYNC_START_PENT = H_BLANK_START_PENT + H_BLANK1_PENT;
	localparam int H_SYNC_STOP_PENT = H_SYNC_START_PENT + H_SYNC_PENT;
	localparam int H_BLANK_STOP_PENT = H_SYNC_STOP_PENT + H_BLANK2_PENT;
	localparam int V_SYNC_START_PENT = V_AREA + V_BBORDER_PENT;
	localparam int V_SYNC_STOP_PENT = V_SYNC_START_PENT + V_SYNC_PENT;

	// frame interrupt, line and column window
	localparam int INT_LINE_128 = 248;
	localparam int INT_FROM_128 = 5;
	localparam int INT_TO_128 = 64;
	localparam int INT_LINE_PENT = 239;
	localparam int INT_FROM_PENT = 318;
	localparam int INT_TO_PENT = 384;

	// port decode: #FE on a0 low, #FF on a0 high, #7FFD on a1 and a15 low
	localparam int FE_DECODE_BIT = 0;
	localparam int FF_DECODE_BIT = 0;
	localparam int P7FFD_DECODE_BIT = 1;
	localparam int P7FFD_HIGH_BIT = 15;

	// port #FE layout, border in 2..0
	localparam int FE_TAPE_OUT = 3;
	localparam int FE_BEEPER = 4;

	// port #7FFD layout
	localparam int P7FFD_BANK_MSB = 2;
	localparam int P7FFD_VBANK = 3;
	localparam int P7FFD_ROM = 4;
	localparam int P7FFD_LOCK = 5;

	// fixed banks behind 4000 and 8000, RAM sits in the top half of the chip
	localparam rambank_t BANK_4000 = 3'd5;
	localparam rambank_t BANK_8000 = 3'd2;
	localparam logic [1:0] RAM_PAGE_HI = 2'b11;

endpackage

// File: source/vram_arbiter.sv
module vram_arbiter (
	input logic clk14,
	input logic rst_n,
	vram_if.arbiter vif,
	output ula_pkg::vram_addr_t va_out,
	output logic n_vrd,
	output logic n_vwr
);

	ula_pkg::ram_page_t last_page;
	ula_pkg::ram_page_t cpu_page;

	// screen requests only come in CPU-idle slots, so no queueing here
	assign vif.screen_grant = vif.screen_req;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			last_page <= '0;
		else if (vif.cpu_sel)
			last_page <= vif.cpu_page;
	end

	// keep the page steady between CPU accesses
	assign cpu_page = vif.cpu_sel ? vif.cpu_page : last_page;

	// a12..a0 of a CPU access come from the CPU address bus directly
	assign va_out = vif.screen_grant ? vif.screen_addr : {cpu_page, 13'd0};

	assign n_vrd = !(vif.cpu_rd && !vif.screen_grant);
	assign n_vwr = !(vif.cpu_wr && !vif.screen_grant);

endmodule

// File: source/vram_if.sv
interface vram_if;
	logic screen_req;
	ula_pkg::vram_addr_t screen_addr;
	logic screen_grant;
	logic cpu_sel;
	ula_pkg::ram_page_t cpu_page;
	logic cpu_rd;
	logic cpu_wr;
	ula_pkg::byte_t vram_d;

	modport fetch (
		output screen_req,
		output screen_addr,
		input screen_grant,
		input cpu_sel,
		input vram_d
	);

	modport mapper (
		output cpu_sel,
		output cpu_page,
		output cpu_rd,
		output cpu_wr
	);

	modport arbiter (
		input screen_req,
		input screen_addr,
		input cpu_sel,
		input cpu_page,
		input cpu_rd,
		input cpu_wr,
		output screen_grant
	);
endinterface

// File: source/zx_ula_top.sv
module zx_ula_top (
	input logic clk14,
	input logic rst_n,
	input logic timing_128,
	input ula_pkg::cpu_addr_t cpu_a,
	input ula_pkg::byte_t cpu_d_in,
	input logic n_mreq,
	input logic n_iorq,
	input logic n_rd,
	input logic n_wr,
	input logic n_m1,
	input logic n_rfsh,
	input logic [4:0] kd,
	input logic tape_in,
	input ula_pkg::byte_t vram_d,
	output logic clkcpu,
	output logic n_int,
	output ula_pkg::byte_t cpu_d_out,
	output logic cpu_d_oe,
	output ula_pkg::vram_addr_t va_out,
	output logic n_vrd,
	output logic n_vwr,
	output logic n_romcs,
	output logic [2:0] ra,
	output logic r,
	output logic g,
	output logic b,
	output logic i,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic beeper,
	output logic tape_out
);

	vram_if vif ();

	ula_pkg::hcount_t hc;
	logic hc0_odd;
	ula_pkg::vcount_t vc;
	logic line_end;
	logic blank;
	logic screen_load;
	logic blink;
	ula_pkg::rambank_t border;
	ula_pkg::rambank_t rambank;
	logic video_bank;
	logic rom_bank;
	ula_pkg::byte_t attr_latch;
	ula_pkg::rgbi_t rgbi;

	// memory data pins feed the fetch through the interface
	assign vif.vram_d = vram_d;
	assign {i, g, r, b} = rgbi;

	// connections by matching names
	raster_timing u_raster (
		.*
	);

	screen_fetch u_fetch (
		.*
	);

	io_ports u_io (
		.*
	);

	mem_mapper u_mapper (
		.*
	);

	vram_arbiter u_arbiter (
		.*
	);

endmodule
